//--- common/keyboard_defs.svh
// Keyboard receiver timing constants
`ifndef KEYBOARD_DEFS_SVH
`define KEYBOARD_DEFS_SVH

// Receiver clock filter
// The synchronized keyboard clock has to hold a new level for this many
// consecutive system clocks before the filtered clock follows it.
// Short glitches on the cable are swallowed this way.
`define PS2_FILTER_LEN 4

// Mid-frame watchdog
// System clocks allowed between two filtered falling edges inside a frame.
// A keyboard clocks at 10 to 16.7 kHz, so a gap much longer than one bit
// period means the frame was cut off.
// The receiver drops the partial frame and flags an error when the count
// is reached.
`define PS2_TIMEOUT_CYCLES 2000

// Both values are counted in system clocks.
// Keep the filter far below half a bit period, or edges get lost.
// Keep the timeout above a full bit period, or slow keyboards fail.





`endif

//--- common/ps2_pkg.sv
// PS/2 line-level types
`default_nettype none

package ps2_pkg;

    // One byte off the wire, as shifted in LSB first
    typedef logic [7:0] scan_code_t;

    // Frame bit index
    // 0 is the start bit, 1 to 8 data, 9 parity, 10 stop
    typedef logic [3:0] bit_count_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,   // Waiting for a start bit edge
        RX_SHIFT = 2'd1,   // Inside a frame
        RX_DONE  = 2'd2    // Stop bit taken, result out this cycle
    } rx_state_t;

endpackage : ps2_pkg

`default_nettype wire

//--- common/arcade_pkg.sv
// Game control types
`default_nettype none

package arcade_pkg;

    // Joystick levels, one bit per switch
    typedef logic [6:0] joy_t;

    localparam int JOY_RIGHT = 0;
    localparam int JOY_LEFT  = 1;
    localparam int JOY_DOWN  = 2;
    localparam int JOY_UP    = 3;
    localparam int JOY_B1    = 4;
    localparam int JOY_B2    = 5;
    localparam int JOY_B3    = 6;

    // Player 1 in bit 0, player 2 in bit 1
    typedef logic [1:0] pair_t;

    localparam int P1 = 0;
    localparam int P2 = 1;

    // Graphics layer enables
    typedef logic [3:0] gfx_t;

    localparam int GFX_CHAR = 0;   // Character layer
    localparam int GFX_SCR1 = 1;
    localparam int GFX_SCR2 = 2;
    localparam int GFX_OBJ  = 3;   // Sprites

endpackage : arcade_pkg

`default_nettype wire

//--- common/key_event_if.sv
// Decoded key event link
`timescale 1ns/1ps
`default_nettype none

interface key_event_if import ps2_pkg::*; ();

    scan_code_t code;       // Scan code without prefixes
    logic       extended;   // Came after E0
    logic       released;   // Came after F0
    logic       strobe;     // One cycle, qualifies the rest

    // Framer side drives the event
    modport framer (
        output code, extended, released, strobe
    );

    // Key map only listens, no back-pressure
    modport map (
        input code, extended, released, strobe
    );

endinterface : key_event_if

`default_nettype wire

//--- ps2/ps2_rx.sv
// PS/2 frame receiver
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_defs.svh"

module ps2_rx import ps2_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output scan_code_t rx_data,
    output logic       rx_valid,
    output logic       rx_error
);

    localparam int FILT_W = $clog2(`PS2_FILTER_LEN + 1);
    localparam int TOUT_W = $clog2(`PS2_TIMEOUT_CYCLES + 1);

    localparam bit_count_t FIRST_DATA = 4'd1;
    localparam bit_count_t LAST_DATA  = 4'd8;
    localparam bit_count_t PARITY_BIT = 4'd9;
    localparam bit_count_t STOP_BIT   = 4'd10;

    logic [1:0]        clk_sync;     // Two-flop synchronizers
    logic [1:0]        data_sync;
    logic              clk_filt;     // Debounced keyboard clock
    logic              clk_filt_d;
    logic [FILT_W-1:0] filt_cnt;     // Run length of a differing level
    logic              fall;
    rx_state_t         state;
    bit_count_t        bit_cnt;
    scan_code_t        shift_q;
    logic              start_bit;
    logic              parity_bit;
    logic              frame_ok;     // Checks of the last frame
    logic [TOUT_W-1:0] tout_cnt;     // Clocks since the last edge
    logic              timeout;

    // Lines idle high
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // Clock follows the line only after a stable run
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_filt   <= 1'b1;
            clk_filt_d <= 1'b1;
            filt_cnt   <= '0;
        end else begin
            clk_filt_d <= clk_filt;
            if (clk_sync[1] == clk_filt) begin
                filt_cnt <= '0;                  // Glitch over, start again
            end else if (filt_cnt == FILT_W'(`PS2_FILTER_LEN - 1)) begin
                clk_filt <= clk_sync[1];
                filt_cnt <= '0;
            end else begin
                filt_cnt <= filt_cnt + 1'b1;
            end
        end
    end

    assign fall    = clk_filt_d & ~clk_filt;  // Keyboard drives data on rise
    assign timeout = (state == RX_SHIFT) && (tout_cnt == TOUT_W'(`PS2_TIMEOUT_CYCLES));

    // Frame FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            tout_cnt <= '0;
            frame_ok <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    tout_cnt <= '0;
                    if (fall) begin
                        state   <= RX_SHIFT;     // Start bit taken
                        bit_cnt <= FIRST_DATA;
                    end
                end
                RX_SHIFT: begin
                    if (timeout) begin
                        state <= RX_IDLE;        // Stalled, drop the frame
                    end else if (fall) begin
                        tout_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == STOP_BIT) begin
                            // Start low, stop high, odd parity over 9 bits
                            frame_ok <= !start_bit && data_sync[1]
                                        && (^{shift_q, parity_bit});
                            state    <= RX_DONE;
                        end
                    end else begin
                        tout_cnt <= tout_cnt + 1'b1;
                    end
                end
                RX_DONE: state <= RX_IDLE;       // Result shown for one cycle
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Bit capture
    always_ff @(posedge clk) begin
        if (fall && state == RX_IDLE) begin
            start_bit <= data_sync[1];
        end else if (fall && state == RX_SHIFT) begin
            if (bit_cnt <= LAST_DATA) begin
                shift_q <= {data_sync[1], shift_q[7:1]};   // LSB first
            end else if (bit_cnt == PARITY_BIT) begin
                parity_bit <= data_sync[1];
            end
        end
    end

    assign rx_data  = shift_q;
    assign rx_valid = (state == RX_DONE) && frame_ok;
    // DONE and SHIFT never overlap, so valid and error stay apart
    assign rx_error = ((state == RX_DONE) && !frame_ok) || timeout;

endmodule : ps2_rx

`default_nettype wire

//--- ps2/scancode_framer.sv
// Scan code prefix framer
`timescale 1ns/1ps
`default_nettype none

module scancode_framer import ps2_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  scan_code_t rx_data,
    input  logic       rx_valid,
    input  logic       rx_error,
    key_event_if.framer ev
);

    localparam scan_code_t CODE_EXT = 8'hE0;   // Extended prefix
    localparam scan_code_t CODE_REL = 8'hF0;   // Break prefix

    logic ext_flag;
    logic rel_flag;

    // Prefix tracking and event strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            ext_flag  <= 1'b0;
            rel_flag  <= 1'b0;
            ev.strobe <= 1'b0;
        end else begin
            ev.strobe <= 1'b0;
            if (rx_error) begin
                ext_flag <= 1'b0;            // Broken sequence, forget prefixes
                rel_flag <= 1'b0;
            end else if (rx_valid) begin
                if (rx_data == CODE_EXT) begin
                    ext_flag <= 1'b1;
                end else if (rx_data == CODE_REL) begin
                    rel_flag <= 1'b1;
                end else begin
                    ev.strobe <= 1'b1;       // Final byte of the code
                    ext_flag  <= 1'b0;
                    rel_flag  <= 1'b0;
                end
            end
        end
    end

    // Event payload, qualified by strobe
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            ev.code     <= rx_data;
            ev.extended <= ext_flag;
            ev.released <= rel_flag;
        end
    end

endmodule : scancode_framer

`default_nettype wire

//--- source/arcade_key_map.sv
// Key event to game control map
`timescale 1ns/1ps
`default_nettype none

module arcade_key_map import ps2_pkg::*, arcade_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    key_event_if.map ev,
    input  logic     frame_error_in,
    output joy_t     joy1,
    output joy_t     joy2,
    output pair_t    coin,
    output pair_t    start,
    output logic     key_reset,
    output logic     key_pause,
    output logic     key_service,
    output gfx_t     gfx,
    output logic     frame_error
);

    scan_code_t code;
    logic       pressed;

    assign code    = ev.code;
    assign pressed = !ev.released;   // Make sets, break clears

    // Held levels
    always_ff @(posedge clk) begin
        if (rst) begin
            joy1        <= '0;
            joy2        <= '0;
            coin        <= '0;
            start       <= '0;
            key_reset   <= 1'b0;
            key_pause   <= 1'b0;
            key_service <= 1'b0;
            gfx         <= '0;
        end else if (ev.strobe) begin
            // Extended flag is part of the key, plain 75 is not up
            case ({ev.extended, code})
                // Player 1, arrows and left-hand modifiers
                {1'b0, 8'h29}: joy1[JOY_B3]    <= pressed;   // Space
                {1'b0, 8'h11}: joy1[JOY_B2]    <= pressed;   // Alt
                {1'b0, 8'h14}: joy1[JOY_B1]    <= pressed;   // Ctrl
                {1'b1, 8'h75}: joy1[JOY_UP]    <= pressed;
                {1'b1, 8'h72}: joy1[JOY_DOWN]  <= pressed;
                {1'b1, 8'h6B}: joy1[JOY_LEFT]  <= pressed;
                {1'b1, 8'h74}: joy1[JOY_RIGHT] <= pressed;
                // Player 2 on letter keys
                {1'b0, 8'h15}: joy2[JOY_B3]    <= pressed;   // Q
                {1'b0, 8'h1B}: joy2[JOY_B2]    <= pressed;   // S
                {1'b0, 8'h1C}: joy2[JOY_B1]    <= pressed;   // A
                {1'b0, 8'h2D}: joy2[JOY_UP]    <= pressed;   // R
                {1'b0, 8'h2B}: joy2[JOY_DOWN]  <= pressed;   // F
                {1'b0, 8'h23}: joy2[JOY_LEFT]  <= pressed;   // D
                {1'b0, 8'h34}: joy2[JOY_RIGHT] <= pressed;   // G
                // Coins on 5 and 6
                {1'b0, 8'h2E}: coin[P1]        <= pressed;
                {1'b0, 8'h36}: coin[P2]        <= pressed;
                // Starts on 1 and 2
                {1'b0, 8'h16}: start[P1]       <= pressed;
                {1'b0, 8'h1E}: start[P2]       <= pressed;
                // System keys
                {1'b0, 8'h4D}: key_pause       <= pressed;   // P
                {1'b0, 8'h04}: key_reset       <= pressed;   // F3
                {1'b0, 8'h06}: key_service     <= pressed;   // F2
                // Layer toggles on F7 to F10
                {1'b0, 8'h83}: gfx[GFX_CHAR]   <= pressed;
                {1'b0, 8'h0A}: gfx[GFX_SCR1]   <= pressed;
                {1'b0, 8'h01}: gfx[GFX_SCR2]   <= pressed;
                {1'b0, 8'h09}: gfx[GFX_OBJ]    <= pressed;
                default: ;                                   // Unmapped key
            endcase
        end
    end

    // Error pulse out to the top, one clock late
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_error <= 1'b0;
        end else begin
            frame_error <= frame_error_in;
        end
    end

endmodule : arcade_key_map

`default_nettype wire

//--- source/arcade_keyboard.sv
// Arcade keyboard input top
`timescale 1ns/1ps
`default_nettype none

module arcade_keyboard import ps2_pkg::*, arcade_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  ps2_clk,       // Keyboard lines
    input  logic  ps2_data,
    output joy_t  joy1,
    output joy_t  joy2,
    output pair_t coin,
    output pair_t start,
    output logic  key_reset,
    output logic  key_pause,
    output logic  key_service,
    output gfx_t  gfx,
    output logic  frame_error    // Bad or stalled frame
);

    scan_code_t rx_data;
    logic       rx_valid;
    logic       rx_error;

    key_event_if ev_if ();   // Framer to map

    ps2_rx ps2_rx_i (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_error (rx_error)
    );

    scancode_framer scancode_framer_i (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_error (rx_error),
        .ev       (ev_if.framer)
    );

    arcade_key_map arcade_key_map_i (
        .clk            (clk),
        .rst            (rst),
        .ev             (ev_if.map),
        .frame_error_in (rx_error),
        .joy1           (joy1),
        .joy2           (joy2),
        .coin           (coin),
        .start          (start),
        .key_reset      (key_reset),
        .key_pause      (key_pause),
        .key_service    (key_service),
        .gfx            (gfx),
        .frame_error    (frame_error)
    );

endmodule : arcade_keyboard

`default_nettype wire

//--- testbench/arcade_keyboard_tb.sv
// Arcade keyboard testbench
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_defs.svh"

module arcade_keyboard_tb import ps2_pkg::*, arcade_pkg::*; ();

    localparam int HALF_BIT     = 20;                           // Clocks per PS/2 half period
    localparam int RESP_TIMEOUT = 4 * HALF_BIT + `PS2_FILTER_LEN + 16;
    localparam int NUM_KEYS     = 25;

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    joy_t       joy1;
    joy_t       joy2;
    pair_t      coin;
    pair_t      start;
    logic       key_reset;
    logic       key_pause;
    logic       key_service;
    gfx_t       gfx;
    logic       frame_error;

    logic [24:0] dut_outs;        // All held levels in reference order
    logic [24:0] ref_state;       // Expected held levels
    logic        ref_ext;         // Expected prefix flags
    logic        ref_rel;
    int          frame_err_count;
    int          exp_errors;
    integer      seed = 23579;

    assign dut_outs = {gfx, key_service, key_pause, key_reset, start, coin, joy2, joy1};

    arcade_keyboard arcade_keyboard_i (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .joy1        (joy1),
        .joy2        (joy2),
        .coin        (coin),
        .start       (start),
        .key_reset   (key_reset),
        .key_pause   (key_pause),
        .key_service (key_service),
        .gfx         (gfx),
        .frame_error (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    // Count error pulses at the stable half of the cycle
    always @(negedge clk) begin
        if (rst) frame_err_count <= 0;
        else if (frame_error) frame_err_count <= frame_err_count + 1;
    end

    // Reference key table as {E0, code} for each bit of dut_outs
    function automatic logic [8:0] key_entry(input int idx);
        case (idx)
            0:  return 9'h174;    // joy1 right
            1:  return 9'h16B;
            2:  return 9'h172;
            3:  return 9'h175;    // joy1 up
            4:  return 9'h014;    // joy1 buttons 1 to 3
            5:  return 9'h011;
            6:  return 9'h029;
            7:  return 9'h034;    // joy2 right, left, down, up
            8:  return 9'h023;
            9:  return 9'h02B;
            10: return 9'h02D;
            11: return 9'h01C;    // joy2 buttons
            12: return 9'h01B;
            13: return 9'h015;
            14: return 9'h02E;    // Coins
            15: return 9'h036;
            16: return 9'h016;    // Starts
            17: return 9'h01E;
            18: return 9'h004;    // Reset, pause, service
            19: return 9'h04D;
            20: return 9'h006;
            21: return 9'h083;    // Layer enables
            22: return 9'h00A;
            23: return 9'h001;
            default: return 9'h009;
        endcase
    endfunction

    // Table position of a key or -1 when unmapped
    function automatic int find_key(input logic ext, input scan_code_t code);
        for (int i = 0; i < NUM_KEYS; i++) begin
            if (key_entry(i) == {ext, code}) return i;
        end
        return -1;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        string line;
        if (got !== exp) begin
            line = $sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run(line);
        end
    endtask

    task automatic compare_outputs();
        check_value("joy1", joy1, ref_state[6:0]);
        check_value("joy2", joy2, ref_state[13:7]);
        check_value("coin", coin, ref_state[15:14]);
        check_value("start", start, ref_state[17:16]);
        check_value("key_reset", key_reset, ref_state[18]);
        check_value("key_pause", key_pause, ref_state[19]);
        check_value("key_service", key_service, ref_state[20]);
        check_value("gfx", gfx, ref_state[24:21]);
        check_value("frame_error pulses", frame_err_count, exp_errors);
    endtask

    // Keyboard model sets data while the clock is high
    task automatic drive_frame(input scan_code_t data, input logic bad_parity,
                               input int nbits);
        logic [10:0] frame;
        frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};   // Odd parity
        for (int i = 0; i < nbits; i++) begin
            @(posedge clk) ps2_data <= frame[i];
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        @(posedge clk) ps2_data <= 1'b1;                     // Back to idle
        repeat (2 * HALF_BIT) @(posedge clk);
    endtask

    // Good byte with the reference following the prefix rule
    task automatic send_byte(input scan_code_t data);
        int idx;
        drive_frame(data, 1'b0, 11);
        if (data == 8'hE0) ref_ext = 1'b1;
        else if (data == 8'hF0) ref_rel = 1'b1;
        else begin
            idx = find_key(ref_ext, data);
            if (idx >= 0) ref_state[idx] = !ref_rel;          // Unmapped changes nothing
            ref_ext = 1'b0;
            ref_rel = 1'b0;
        end
    endtask

    task automatic wait_outputs();
        int n;
        n = 0;
        while (dut_outs !== ref_state && n < RESP_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (dut_outs !== ref_state) begin
            abort_run("timeout: outputs never reached the expected levels");
        end
        compare_outputs();
    endtask

    task automatic wait_frame_error(input int limit);
        int n;
        n = 0;
        while (frame_err_count != exp_errors && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (frame_err_count != exp_errors) begin
            abort_run("timeout: frame_error never pulsed");
        end
        compare_outputs();
    endtask

    // Broken parity or a short frame drops any prefix
    task automatic send_bad_frame(input scan_code_t data, input int nbits);
        drive_frame(data, 1'b1, nbits);
        exp_errors++;
        ref_ext = 1'b0;
        ref_rel = 1'b0;
        wait_frame_error(`PS2_TIMEOUT_CYCLES + RESP_TIMEOUT);
    endtask

    task automatic press_key(input int idx);
        logic [8:0] key;
        key = key_entry(idx);
        if (key[8]) send_byte(8'hE0);
        send_byte(key[7:0]);
        wait_outputs();
    endtask

    task automatic release_key(input int idx);
        logic [8:0] key;
        key = key_entry(idx);
        if (key[8]) send_byte(8'hE0);
        send_byte(8'hF0);
        send_byte(key[7:0]);
        wait_outputs();
    endtask

    task automatic reset_state();
        repeat (200) @(negedge clk);                         // Lines idle high
        check_value("reset outputs", dut_outs, 0);
        compare_outputs();
    endtask

    task automatic plain_keys();
        for (int i = 0; i < NUM_KEYS; i++) begin
            if (!(key_entry(i) & 9'h100)) begin
                press_key(i);
                check_value("single key outputs", dut_outs, 32'd1 << i);
                release_key(i);
            end
        end
        send_byte(8'h1A);                                    // Unmapped make and break
        send_byte(8'hF0);
        send_byte(8'h5A);
        wait_outputs();
    endtask

    task automatic extended_keys();
        press_key(3);                                        // E0 75
        check_value("joy1", joy1, 7'h08);
        release_key(3);
        send_byte(8'h75);                                    // Keypad 8 is no arrow
        wait_outputs();
        check_value("joy1", joy1, 7'h00);
    endtask

    task automatic parity_error();
        send_bad_frame(8'h29, 11);
        send_byte(8'hF0);
        send_bad_frame(8'h1C, 11);                           // Break prefix lost here
        send_byte(8'h29);
        wait_outputs();
        check_value("joy1", joy1, 7'h40);                    // Button 3 still held
        release_key(6);
    endtask

    task automatic stall_timeout();
        send_bad_frame(8'h16, 5);
        press_key(16);
        release_key(16);
    endtask

    task automatic random_sequence();
        int idx;
        for (int n = 0; n < 60; n++) begin
            idx = ($random(seed) & 32'h7FFF_FFFF) % NUM_KEYS;
            if ($random(seed) & 1) press_key(idx);
            else release_key(idx);
        end
    endtask

    initial begin
        rst             = 1'b1;
        ps2_clk         = 1'b1;
        ps2_data        = 1'b1;
        ref_state       = '0;
        ref_ext         = 1'b0;
        ref_rel         = 1'b0;
        exp_errors      = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        plain_keys();
        extended_keys();
        parity_error();
        stall_timeout();
        random_sequence();
        repeat (50) @(negedge clk);
        if (frame_err_count == exp_errors) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("unexpected frame_error pulses at the end of the run");
        end
    end

endmodule : arcade_keyboard_tb

`default_nettype wire

//--- sources.f
+incdir+common
common/ps2_pkg.sv
common/arcade_pkg.sv
common/key_event_if.sv
ps2/ps2_rx.sv
ps2/scancode_framer.sv
source/arcade_key_map.sv
source/arcade_keyboard.sv
testbench/arcade_keyboard_tb.sv
